//--- fpuPkg.sv
// Widths, encodings and control types shared by the FPU RTL and its testbench
// Modules import it inside their body and use scoped names in their port lists

package fpuPkg;

  //////////////////////////////
  // Format and encodings
  //////////////////////////////

  localparam int ExpBits  = 8;    // Single-precision exponent field
  localparam int FracBits = 23;   // Stored fraction, hidden bit not included

  localparam logic [6:0]  OpcodeOpFp   = 7'b1010011;   // OP-FP major opcode
  localparam logic [31:0] CanonicalNaN = 32'h7fc00000;  // Positive quiet NaN, zero payload

  // funct7 values of the single-precision ops handled here
  localparam logic [6:0] Funct7Sgnj    = 7'b0010000;   // fsgnj, fsgnjn, fsgnjx
  localparam logic [6:0] Funct7MinMax  = 7'b0010100;   // fmin, fmax
  localparam logic [6:0] Funct7Cmp     = 7'b1010000;   // fle, flt, feq
  localparam logic [6:0] Funct7MvXWCls = 7'b1110000;   // fmv.x.w and fclass share this one
  localparam logic [6:0] Funct7MvWX    = 7'b1111000;   // fmv.w.x

  //////////////////////////////
  // Data types
  //////////////////////////////

  typedef logic [31:0] wordT;    // FP value, integer source or integer result
  typedef logic [4:0]  regAdrT;  // FP register address
  typedef logic [31:0] instrT;   // Raw instruction word

  // Operation class carried down the pipe
  // opNone must stay at zero so a cleared control word is a bubble
  typedef enum logic [2:0] {
    opNone,
    opSgnj,
    opMinMax,
    opCmp,
    opClass,
    opMvXW,    // FP register to integer result
    opMvWX     // Integer source to FP register
  } fpOpT;

  // Per-instruction control, one copy per stage
  typedef struct packed {
    fpOpT       op;
    logic [2:0] funct3;     // Selects the variant within op
    regAdrT     rd;
    regAdrT     rs1;
    regAdrT     rs2;
    logic       fRegWrite;  // Writes the FP register file in W
    logic       intWrite;   // Produces FIntResM in M
    logic       uses1;      // Reads rs1 from the FP file
    logic       uses2;      // Reads rs2 from the FP file
  } fpCtrlT;

  // Operand classification from the unpacker
  typedef struct packed {
    logic sign;
    logic zero;
    logic subnorm;
    logic norm;
    logic inf;
    logic nan;      // Any NaN
    logic snan;     // Signaling, quiet bit clear
    logic quiet;    // Quiet NaN
  } fpClassT;

  // Operand source in execute, M has priority over W
  typedef enum logic [1:0] {
    fwdReg,   // Value read from the register file in D
    fwdW,     // Result sitting in writeback
    fwdM      // Result sitting in memory stage
  } fwdSelT;

endpackage

//--- fpuDecoder.sv
// OP-FP decoder for the single-precision subset
// Turns the decode-stage instruction into a control word and an illegal flag

module fpuDecoder (
  input  fpuPkg::instrT  InstrD,
  output fpuPkg::fpCtrlT Ctrl,
  output logic           Illegal
);
  import fpuPkg::*;

  logic [6:0] funct7;
  logic [2:0] funct3;
  regAdrT     rs2;
  fpOpT       op;
  logic       fWr, iWr;     // FP / integer write
  logic       use1, use2;   // FP sources read

  assign funct7 = InstrD[31:25];
  assign funct3 = InstrD[14:12];
  assign rs2    = InstrD[24:20];

  // Match funct7, then narrow by funct3 and the rs2 field of unary ops
  always_comb begin
    op   = opNone;
    fWr  = 1'b0;
    iWr  = 1'b0;
    use1 = 1'b0;
    use2 = 1'b0;
    if (InstrD[6:0] == OpcodeOpFp) begin
      case (funct7)
        Funct7Sgnj: if (funct3 <= 3'd2) begin       // j, jn, jx
          op   = opSgnj;
          fWr  = 1'b1;
          use1 = 1'b1;
          use2 = 1'b1;
        end
        Funct7MinMax: if (funct3 <= 3'd1) begin     // min, max
          op   = opMinMax;
          fWr  = 1'b1;
          use1 = 1'b1;
          use2 = 1'b1;
        end
        Funct7Cmp: if (funct3 <= 3'd2) begin        // le, lt, eq
          op   = opCmp;
          iWr  = 1'b1;
          use1 = 1'b1;
          use2 = 1'b1;
        end
        Funct7MvXWCls: if (rs2 == '0 && funct3 <= 3'd1) begin
          op   = (funct3 == 3'd0) ? opMvXW : opClass;
          iWr  = 1'b1;
          use1 = 1'b1;
        end
        Funct7MvWX: if (rs2 == '0 && funct3 == 3'd0) begin
          op  = opMvWX;     // Source is the integer operand, no FP read
          fWr = 1'b1;
        end
        default: ;
      endcase
    end
  end

  assign Illegal = (op == opNone);

  // Illegal words leave a fully cleared control word, i.e. a bubble
  always_comb begin
    Ctrl = '0;
    if (!Illegal) begin
      Ctrl.op        = op;
      Ctrl.funct3    = funct3;
      Ctrl.rd        = InstrD[11:7];
      Ctrl.rs1       = InstrD[19:15];
      Ctrl.rs2       = rs2;
      Ctrl.fRegWrite = fWr;
      Ctrl.intWrite  = iWr;
      Ctrl.uses1     = use1;
      Ctrl.uses2     = use2;
    end
  end

  // Legal ops write exactly one register file, illegal ones neither
  illegalNoWrite: assert final (Illegal ? !(Ctrl.fRegWrite || Ctrl.intWrite)
                                        : (Ctrl.fRegWrite ^ Ctrl.intWrite))
    else $error("decoder write bits inconsistent with Illegal");

endmodule

//--- fpRegFile.sv
// 32 x 32 FP register file, two read ports and one write port
// A read of the register being written returns the incoming data

module fpRegFile (
  input  logic           clk,
  input  logic           rst,
  input  fpuPkg::regAdrT Adr1,
  input  fpuPkg::regAdrT Adr2,
  input  fpuPkg::regAdrT WrAdr,
  input  fpuPkg::wordT   WrData,
  input  logic           WrEn,
  output fpuPkg::wordT   Rd1,
  output fpuPkg::wordT   Rd2
);
  import fpuPkg::*;

  wordT regs [32];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 32; i++)
        regs[i] <= '0;           // All registers start at +0
    end else if (WrEn) begin
      regs[WrAdr] <= WrData;
    end
  end

  // Write-through covers a W-stage writer and a D-stage reader in the same cycle
  assign Rd1 = (WrEn && WrAdr == Adr1) ? WrData : regs[Adr1];
  assign Rd2 = (WrEn && WrAdr == Adr2) ? WrData : regs[Adr2];

  wrDataKnown: assert property (@(posedge clk) disable iff (rst) WrEn |-> !$isunknown(WrData))
    else $error("unknown data written to FP register %0d", WrAdr);

endmodule

//--- fpForward.sv
// Forwarding select for the two execute operands
// Memory-stage results win over writeback results for the same register

module fpForward (
  input  fpuPkg::fpCtrlT CtrlE,
  input  fpuPkg::fpCtrlT CtrlM,
  input  fpuPkg::fpCtrlT CtrlW,
  output fpuPkg::fwdSelT Fwd1,
  output fpuPkg::fwdSelT Fwd2
);
  import fpuPkg::*;

  // One source: nearest older writer of the same register, else the file value
  function automatic fwdSelT pickSrc(input regAdrT src, input logic used,
                                     input fpCtrlT m, input fpCtrlT w);
    if (used && m.fRegWrite && m.rd == src)
      return fwdM;
    else if (used && w.fRegWrite && w.rd == src)
      return fwdW;
    else
      return fwdReg;
  endfunction

  assign Fwd1 = pickSrc(CtrlE.rs1, CtrlE.uses1, CtrlM, CtrlW);
  assign Fwd2 = pickSrc(CtrlE.rs2, CtrlE.uses2, CtrlM, CtrlW);

  // A select may only name a stage that is really writing the FP file
  fwdTargetsWriter: assert final ((Fwd1 != fwdM || CtrlM.fRegWrite) &&
                                  (Fwd1 != fwdW || CtrlW.fRegWrite) &&
                                  (Fwd2 != fwdM || CtrlM.fRegWrite) &&
                                  (Fwd2 != fwdW || CtrlW.fRegWrite))
    else $error("forward select points at a non-writing stage");

endmodule

//--- fpUnpack.sv
// Single-precision operand classifier
// Splits the word into sign, exponent and fraction and flags its IEEE class

module fpUnpack (
  input  fpuPkg::wordT    Op,
  output fpuPkg::fpClassT Cls
);
  import fpuPkg::*;

  logic [ExpBits-1:0]  expo;
  logic [FracBits-1:0] frac;
  logic                expOnes;   // Inf or NaN
  logic                expZero;   // Zero or subnormal
  logic                fracZero;
  logic                isNaN;

  assign expo = Op[FracBits +: ExpBits];
  assign frac = Op[FracBits-1:0];

  assign expOnes  = &expo;
  assign expZero  = ~|expo;
  assign fracZero = ~|frac;
  assign isNaN    = expOnes & ~fracZero;

  assign Cls.sign    = Op[ExpBits+FracBits];
  assign Cls.zero    = expZero & fracZero;
  assign Cls.subnorm = expZero & ~fracZero;
  assign Cls.norm    = ~expZero & ~expOnes;
  assign Cls.inf     = expOnes & fracZero;

  // Fraction MSB is the quiet bit
  assign Cls.nan   = isNaN;
  assign Cls.snan  = isNaN & ~frac[FracBits-1];
  assign Cls.quiet = isNaN & frac[FracBits-1];

endmodule

//--- fpCompare.sv
// Compare unit: feq/flt/fle bit, fmin/fmax result and the invalid flag
// Ordering is by sign and magnitude, no subtraction needed

module fpCompare (
  input  fpuPkg::wordT    X,
  input  fpuPkg::wordT    Y,
  input  fpuPkg::fpClassT XCls,
  input  fpuPkg::fpClassT YCls,
  input  logic [2:0]      Funct3,     // 010 eq, 001 lt, 000 le / 000 min, 001 max
  input  logic            IsMinMax,
  output logic            CmpBit,
  output fpuPkg::wordT    MinMax,
  output logic            Invalid
);
  import fpuPkg::*;

  logic anyNaN, anySNaN, bothZero;
  logic magLt, magGt;     // |X| < |Y|, |X| > |Y|
  logic xBelowY;          // Total order, -0 below +0
  logic eq, lt;

  assign anyNaN   = XCls.nan | YCls.nan;
  assign anySNaN  = XCls.snan | YCls.snan;
  assign bothZero = XCls.zero & YCls.zero;

  // Exponent and fraction compare as one unsigned field
  assign magLt = X[ExpBits+FracBits-1:0] < Y[ExpBits+FracBits-1:0];
  assign magGt = Y[ExpBits+FracBits-1:0] < X[ExpBits+FracBits-1:0];

  // Differing signs decide alone; two negatives reverse the magnitude order
  assign xBelowY = (XCls.sign != YCls.sign) ? XCls.sign : (XCls.sign ? magGt : magLt);

  assign eq = ~anyNaN & ((X == Y) | bothZero);   // +0 == -0
  assign lt = ~anyNaN & xBelowY & ~bothZero;

  always_comb begin
    case (Funct3)
      3'b010:  CmpBit = eq;
      3'b001:  CmpBit = lt;
      3'b000:  CmpBit = lt | eq;
      default: CmpBit = 1'b0;
    endcase
  end

  // feq and min/max only trap on signaling NaN, flt/fle on any NaN
  assign Invalid = IsMinMax ? anySNaN :
                   (Funct3 == 3'b010) ? anySNaN :
                   (Funct3 == 3'b001 || Funct3 == 3'b000) ? anyNaN : 1'b0;

  always_comb begin
    if (XCls.nan && YCls.nan)
      MinMax = CanonicalNaN;
    else if (XCls.nan)
      MinMax = Y;                                 // NaN loses to a number
    else if (YCls.nan)
      MinMax = X;
    else if (Funct3[0])
      MinMax = xBelowY ? Y : X;                   // fmax
    else
      MinMax = xBelowY ? X : Y;                   // fmin
  end

endmodule

//--- fpSignClass.sv
// Sign injection and fclass for single precision
// Both are pure bit manipulation on the first operand

module fpSignClass (
  input  fpuPkg::wordT    X,
  input  fpuPkg::wordT    Y,
  input  fpuPkg::fpClassT XCls,
  input  logic [2:0]      Funct3,    // 0 fsgnj, 1 fsgnjn, 2 fsgnjx
  output fpuPkg::wordT    SgnRes,
  output fpuPkg::wordT    ClassMask
);
  import fpuPkg::*;

  logic ySign;
  logic newSign;

  assign ySign = Y[ExpBits+FracBits];

  always_comb begin
    case (Funct3)
      3'd1:    newSign = ~ySign;              // Negated sign of Y
      3'd2:    newSign = XCls.sign ^ ySign;   // Product of both signs
      default: newSign = ySign;
    endcase
  end

  // Magnitude of X passes untouched, NaN payloads included
  assign SgnRes = {newSign, X[ExpBits+FracBits-1:0]};

  // One-hot class in RISC-V fclass bit order
  always_comb begin
    ClassMask    = '0;
    ClassMask[0] = XCls.sign & XCls.inf;
    ClassMask[1] = XCls.sign & XCls.norm;
    ClassMask[2] = XCls.sign & XCls.subnorm;
    ClassMask[3] = XCls.sign & XCls.zero;
    ClassMask[4] = ~XCls.sign & XCls.zero;
    ClassMask[5] = ~XCls.sign & XCls.subnorm;
    ClassMask[6] = ~XCls.sign & XCls.norm;
    ClassMask[7] = ~XCls.sign & XCls.inf;
    ClassMask[8] = XCls.snan;        // NaN classes ignore the sign
    ClassMask[9] = XCls.quiet;
  end

endmodule

//--- fpu.sv
// Four-stage single-precision FPU (decode, execute, memory, writeback)
// Every op finishes in execute; results move on to M for the core and W for the FP file
// Stall from the core freezes the whole pipe, FlushE drops the instruction leaving D

module fpu (
  input  logic          clk,
  input  logic          rst,
  input  logic          Stall,              // Freezes every pipeline register
  input  logic          FlushE,             // Bubble into E
  input  fpuPkg::instrT InstrD,
  input  fpuPkg::wordT  SrcAE,              // Integer operand for fmv.w.x, sampled in E
  output logic          IllegalFpuInstrD,
  output logic          FIntWriteM,         // Integer result valid this cycle
  output fpuPkg::wordT  FIntResM,
  output logic          SetInvalidM
);
  import fpuPkg::*;

  fpCtrlT  ctrlD, ctrlE, ctrlM, ctrlW;
  wordT    rd1D, rd2D, rd1E, rd2E;
  fwdSelT  fwd1E, fwd2E;
  wordT    xE, yE;                          // Operands after forwarding
  fpClassT xClsE, yClsE;
  logic    cmpBitE, invalidE, setInvalidE;
  wordT    minMaxE, sgnResE, classMaskE;
  wordT    fpResE, intResE;
  wordT    fpResM, fpResW;

  function automatic wordT fwdMux(input fwdSelT sel, input wordT regVal,
                                  input wordT resM, input wordT resW);
    case (sel)
      fwdM:    return resM;
      fwdW:    return resW;
      default: return regVal;
    endcase
  endfunction

  //////////////////////////////
  // Decode
  //////////////////////////////

  fpuDecoder decoder (.InstrD, .Ctrl(ctrlD), .Illegal(IllegalFpuInstrD));

  // W writes only on the edge where it moves on
  fpRegFile regFile (.clk, .rst, .Adr1(ctrlD.rs1), .Adr2(ctrlD.rs2),
                     .WrAdr(ctrlW.rd), .WrData(fpResW), .WrEn(ctrlW.fRegWrite & ~Stall),
                     .Rd1(rd1D), .Rd2(rd2D));

  always_ff @(posedge clk) begin
    if (rst)
      ctrlE <= '0;
    else if (!Stall) begin
      if (FlushE)
        ctrlE <= '0;                        // Squashed, illegal words are already cleared
      else
        ctrlE <= ctrlD;
    end
  end

  always_ff @(posedge clk) begin
    if (!Stall) begin
      rd1E <= rd1D;
      rd2E <= rd2D;
    end
  end

  //////////////////////////////
  // Execute
  //////////////////////////////

  fpForward forward (.CtrlE(ctrlE), .CtrlM(ctrlM), .CtrlW(ctrlW), .Fwd1(fwd1E), .Fwd2(fwd2E));

  assign xE = fwdMux(fwd1E, rd1E, fpResM, fpResW);
  assign yE = fwdMux(fwd2E, rd2E, fpResM, fpResW);

  fpUnpack unpackX (.Op(xE), .Cls(xClsE));
  fpUnpack unpackY (.Op(yE), .Cls(yClsE));

  fpCompare compare (.X(xE), .Y(yE), .XCls(xClsE), .YCls(yClsE), .Funct3(ctrlE.funct3),
                     .IsMinMax(ctrlE.op == opMinMax), .CmpBit(cmpBitE), .MinMax(minMaxE),
                     .Invalid(invalidE));

  fpSignClass signClass (.X(xE), .Y(yE), .XCls(xClsE), .Funct3(ctrlE.funct3),
                         .SgnRes(sgnResE), .ClassMask(classMaskE));

  // Result muxes, FP side and integer side
  always_comb begin
    fpResE  = sgnResE;
    intResE = '0;
    case (ctrlE.op)
      opMinMax: fpResE  = minMaxE;
      opMvWX:   fpResE  = SrcAE;            // Raw bits, no conversion
      opCmp:    intResE = wordT'(cmpBitE);
      opClass:  intResE = classMaskE;
      opMvXW:   intResE = xE;               // Raw bits of the FP register
      default: ;
    endcase
  end

  assign setInvalidE = invalidE & (ctrlE.op == opCmp || ctrlE.op == opMinMax);

  //////////////////////////////
  // Memory and writeback
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      ctrlM       <= '0;
      ctrlW       <= '0;
      SetInvalidM <= 1'b0;
    end else if (!Stall) begin
      ctrlM       <= ctrlE;
      ctrlW       <= ctrlM;
      SetInvalidM <= setInvalidE;
    end
  end

  always_ff @(posedge clk) begin
    if (!Stall) begin
      fpResM   <= fpResE;
      FIntResM <= intResE;
      fpResW   <= fpResM;                   // Only the FP result goes on to W
    end
  end

  assign FIntWriteM = ctrlM.intWrite;

  // An op in M feeds either the core or the FP file, never both
  oneWriteInM: assert property (@(posedge clk) disable iff (rst)
                                !(FIntWriteM && ctrlM.fRegWrite))
    else $error("M stage writes both register files");

endmodule

//--- tbFpuChecker.sv
// Scoreboard for the FPU testbench
// Follows stage occupancy from Stall and FlushE, keeps a reference FP register file
// and compares the illegal flag and every M-stage output against it

module tbFpuChecker (
  input  logic          clk,
  input  logic          rst,
  input  logic          Stall,
  input  logic          FlushE,
  input  fpuPkg::instrT InstrD,
  input  fpuPkg::wordT  SrcAE,
  input  logic          IllegalFpuInstrD,
  input  logic          FIntWriteM,
  input  fpuPkg::wordT  FIntResM,
  input  logic          SetInvalidM,
  output int            errorCount,
  output int            checkCount,
  output logic          pipeEmpty       // No instruction left in E, M or W
);
  timeunit 1ns;
  timeprecision 1ps;
  import fpuPkg::*;

  // Expected M-stage outputs of one instruction
  typedef struct packed {
    logic valid;
    fpOpT op;
    logic intWrite;
    wordT intRes;
    logic invalid;
  } expectedT;

  fpCtrlT   eSlot;                  // Instruction sitting in E
  expectedT mSlot;                  // What M must show
  logic     wBusy;                  // W occupied
  logic     resetSeen = 1'b0;
  wordT     refRegs [32];           // Architectural FP registers, program order

  //////////////////////////////
  // Reference rules
  //////////////////////////////

  // RISC-V OP-FP single-precision encodings, by funct7, funct3 and rs2
  function automatic fpCtrlT decodeRef(input instrT i);
    fpCtrlT     c;
    logic [6:0] f7;
    logic [2:0] f3;
    logic       unary;
    c     = '0;
    f7    = i[31:25];
    f3    = i[14:12];
    unary = (i[24:20] == 5'd0);
    if (i[6:0] != 7'b1010011)
      return c;
    if (f7 == 7'h10 && f3 < 3'd3) c.op = opSgnj;
    else if (f7 == 7'h14 && f3 < 3'd2) c.op = opMinMax;
    else if (f7 == 7'h50 && f3 < 3'd3) c.op = opCmp;
    else if (f7 == 7'h70 && unary && f3 == 3'd0) c.op = opMvXW;
    else if (f7 == 7'h70 && unary && f3 == 3'd1) c.op = opClass;
    else if (f7 == 7'h78 && unary && f3 == 3'd0) c.op = opMvWX;
    else return c;                  // Illegal word travels as a bubble
    c.funct3    = f3;
    c.rd        = i[11:7];
    c.rs1       = i[19:15];
    c.rs2       = i[24:20];
    c.intWrite  = (c.op == opCmp || c.op == opClass || c.op == opMvXW);
    c.fRegWrite = !c.intWrite;
    return c;
  endfunction

  function automatic logic isNan(input wordT w);
    return (w[30:23] == 8'hff) && (w[22:0] != '0);
  endfunction

  function automatic logic isSnan(input wordT w);
    return isNan(w) && !w[22];     // Quiet bit clear
  endfunction

  function automatic logic isZero(input wordT w);
    return w[30:0] == '0;
  endfunction

  // Unsigned key that follows numeric order, -0 just below +0
  function automatic wordT orderKey(input wordT w);
    return w[31] ? ~w : (w | 32'h8000_0000);
  endfunction

  // Bit position of the fclass result
  function automatic int classIndex(input wordT w);
    if (isNan(w)) return w[22] ? 9 : 8;
    if (w[30:23] == 8'hff) return w[31] ? 0 : 7;
    if (isZero(w)) return w[31] ? 3 : 4;
    if (w[30:23] == 8'h00) return w[31] ? 2 : 5;
    return w[31] ? 1 : 6;
  endfunction

  // Result of one instruction; FP writes land in the register model right away
  task automatic executeRef(input fpCtrlT c, input wordT src, output expectedT res);
    wordT a;
    wordT b;
    wordT r;
    logic unordered;
    logic eqv;
    logic ltv;
    a         = refRegs[c.rs1];
    b         = refRegs[c.rs2];
    unordered = isNan(a) || isNan(b);
    eqv       = !unordered && (a == b || (isZero(a) && isZero(b)));
    ltv       = !unordered && !(isZero(a) && isZero(b)) && orderKey(a) < orderKey(b);
    res          = '0;
    res.valid    = 1'b1;
    res.op       = c.op;
    res.intWrite = c.intWrite;
    case (c.op)
      opSgnj: begin
        case (c.funct3)
          3'd0:    r = {b[31], a[30:0]};
          3'd1:    r = {~b[31], a[30:0]};
          default: r = {a[31] ^ b[31], a[30:0]};
        endcase
        refRegs[c.rd] = r;
      end
      opMinMax: begin
        if (isNan(a) && isNan(b)) r = CanonicalNaN;
        else if (isNan(a)) r = b;
        else if (isNan(b)) r = a;
        else if ((orderKey(a) < orderKey(b)) == (c.funct3 == 3'd0)) r = a;   // min keeps lower
        else r = b;
        refRegs[c.rd] = r;
        res.invalid   = isSnan(a) || isSnan(b);
      end
      opCmp: begin
        case (c.funct3)
          3'd2:    res.intRes = {31'b0, eqv};
          3'd1:    res.intRes = {31'b0, ltv};
          default: res.intRes = {31'b0, ltv || eqv};
        endcase
        res.invalid = (c.funct3 == 3'd2) ? (isSnan(a) || isSnan(b)) : unordered;
      end
      opClass: res.intRes = 32'd1 << classIndex(a);
      opMvXW:  res.intRes = a;        // Raw bits
      opMvWX:  refRegs[c.rd] = src;   // Integer operand as seen in E
      default: ;
    endcase
  endtask

  task automatic expectWord(input string what, input wordT got, input wordT exp);
    checkCount++;
    if (got !== exp) begin
      errorCount++;
      $display("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  //////////////////////////////
  // Pipeline model
  //////////////////////////////

  always @(posedge clk) begin
    expectedT nextM;
    if (rst) begin
      resetSeen = 1'b1;
      eSlot     = '0;
      mSlot     = '0;
      wBusy     = 1'b0;
      foreach (refRegs[i])
        refRegs[i] = '0;
    end else if (!Stall) begin       // Stalled edges move nothing
      nextM = '0;
      if (eSlot.op != opNone)
        executeRef(eSlot, SrcAE, nextM);
      wBusy = mSlot.valid;
      mSlot = nextM;
      if (FlushE)
        eSlot = '0;
      else
        eSlot = decodeRef(InstrD);
    end
    pipeEmpty = (eSlot.op == opNone) && !mSlot.valid && !wBusy;
  end

  // Outputs are settled by the falling edge
  always @(negedge clk) begin
    fpCtrlT dec;
    if (resetSeen && !rst) begin
      dec = decodeRef(InstrD);
      expectWord("IllegalFpuInstrD", wordT'(IllegalFpuInstrD), wordT'(dec.op == opNone));
      expectWord("FIntWriteM", wordT'(FIntWriteM), wordT'(mSlot.intWrite));
      expectWord("SetInvalidM", wordT'(SetInvalidM), wordT'(mSlot.invalid));
      if (mSlot.intWrite)
        expectWord("FIntResM", FIntResM, mSlot.intRes);
      if (mSlot.op == opClass)
        expectWord("fclass bits set", wordT'($countones(FIntResM)), 32'd1);
    end
  end

endmodule

//--- tbFpu.sv
// Top-level testbench for the FPU
// Seeded random OP-FP traffic with random stall, flush and integer operand
// All comparing is done in tbFpuChecker

module tbFpu;
  timeunit 1ns;
  timeprecision 1ps;
  import fpuPkg::*;

  localparam int NumInstr   = 3000;
  localparam int MaxCycles  = 20000;   // Limit of the stimulus loop
  localparam int DrainLimit = 50;

  logic  clk = 1'b0;
  logic  rst;
  logic  Stall;
  logic  FlushE;
  instrT InstrD;
  wordT  SrcAE;
  logic  IllegalFpuInstrD;
  logic  FIntWriteM;
  wordT  FIntResM;
  logic  SetInvalidM;
  int    errorCount;
  int    checkCount;
  logic  pipeEmpty;

  always #5 clk = ~clk;

  fpu dut (.*);
  tbFpuChecker scoreboard (.*);

  //////////////////////////////
  // Stimulus helpers
  //////////////////////////////

  function automatic instrT encode(input logic [6:0] f7, input logic [2:0] f3,
                                   input regAdrT rs2, input regAdrT rs1, input regAdrT rd);
    return {f7, rs2, rs1, f3, rd, OpcodeOpFp};
  endfunction

  // Half the picks fall in x0..x7 so back-to-back dependencies are common
  function automatic regAdrT pickReg();
    if ($urandom_range(1))
      return regAdrT'($urandom_range(7));
    return regAdrT'($urandom);
  endfunction

  // Integer operand that is an IEEE corner value half the time
  function automatic wordT pickSrc();
    wordT r;
    r = $urandom;
    if ($urandom_range(1))
      return r;
    case ($urandom_range(6))
      0: return 32'h0000_0000;
      1: return 32'h8000_0000;
      2: return 32'h7f80_0000;                          // +inf
      3: return 32'hff80_0000;                          // -inf
      4: return {r[31], 8'hff, 1'b1, r[21:0]};          // Quiet NaN
      5: return {r[31], 8'hff, 1'b0, r[21:1], 1'b1};    // Signaling NaN with a nonzero fraction
      default: return {r[31], 8'h00, r[22:1], 1'b1};    // Subnormal
    endcase
  endfunction

  function automatic instrT pickInstr();
    instrT w;
    w = $urandom;
    if ($urandom_range(99) < 10) begin
      if (w[7])
        w[6:0] = OpcodeOpFp;       // Random funct fields make it nearly always illegal
      return w;
    end
    case ($urandom_range(6))
      0: return encode(Funct7Sgnj, 3'($urandom_range(2)), pickReg(), pickReg(), pickReg());
      1: return encode(Funct7MinMax, 3'($urandom_range(1)), pickReg(), pickReg(), pickReg());
      2: return encode(Funct7Cmp, 3'($urandom_range(2)), pickReg(), pickReg(), w[11:7]);
      3: return encode(Funct7MvXWCls, 3'd1, 5'd0, pickReg(), w[11:7]);   // fclass
      4: return encode(Funct7MvXWCls, 3'd0, 5'd0, pickReg(), w[11:7]);   // fmv.x.w
      default: return encode(Funct7MvWX, 3'd0, 5'd0, w[19:15], pickReg());
    endcase
  endfunction

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    int   issued;
    int   cycles;
    int   waited;
    logic timedOut;
    issued   = 0;
    cycles   = 0;
    waited   = 0;
    timedOut = 1'b0;
    rst      = 1'b1;
    Stall    = 1'b0;
    FlushE   = 1'b0;
    InstrD   = '0;
    SrcAE    = '0;
    void'($urandom(32'h6e4c_291a));

    repeat (16) @(posedge clk);
    #1 rst = 1'b0;

    while (issued < NumInstr && cycles < MaxCycles) begin
      SrcAE = pickSrc();
      if (issued < 32) begin
        Stall  = 1'b0;
        FlushE = 1'b0;
        InstrD = encode(Funct7MvWX, 3'd0, 5'd0, 5'd0, regAdrT'(issued));   // Fill every register
      end else begin
        Stall  = ($urandom_range(99) < 15);
        FlushE = ($urandom_range(99) < 10);
        if (!Stall)
          InstrD = pickInstr();     // D keeps its word while stalled
      end
      if (!Stall)
        issued++;
      cycles++;
      @(posedge clk);
      #1;
    end
    if (issued < NumInstr) begin
      timedOut = 1'b1;
      $display("Stimulus stopped at the cycle limit after %0d instructions", issued);
    end

    // Illegal words as filler until the pipe is empty
    InstrD = '0;
    Stall  = 1'b0;
    FlushE = 1'b0;
    while (!timedOut && !pipeEmpty && waited < DrainLimit) begin
      @(posedge clk);
      #1;
      waited++;
    end
    if (!timedOut && !pipeEmpty) begin
      timedOut = 1'b1;
      $display("Pipeline did not drain within %0d cycles", DrainLimit);
    end

    // Counts are final once the falling-edge checks of the last cycle have run
    @(posedge clk);
    $display("Checks: %0d, errors: %0d, timeouts: %0d", checkCount, errorCount, timedOut);
    if (errorCount == 0 && !timedOut)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

endmodule

//--- fpu.f
fpuPkg.sv
fpuDecoder.sv
fpRegFile.sv
fpForward.sv
fpUnpack.sv
fpCompare.sv
fpSignClass.sv
fpu.sv
tbFpuChecker.sv
tbFpu.sv
